// File: dv/uart_tb.sv
// assumes nco 8000 hex so one serial bit is exactly 32 clocks; FifoDepth here must match the DUT
`default_nettype none

module uart_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int FifoDepth = 32;
  localparam int LvlW = $clog2(FifoDepth) + 1;
  localparam int ClkHalf = 20;
  localparam int BitCycles = 32;
  localparam int WaitLimit = 20000;
  localparam uart_pkg::nco_t NcoBaud = uart_pkg::nco_t'(16'h8000);

  logic                 clk_i = 1'b0;
  logic                 rst_ni;
  uart_pkg::nco_t       nco_i;
  logic                 tx_en_i;
  logic                 rx_en_i;
  logic                 parity_en_i;
  logic                 parity_odd_i;
  logic                 tx_fifo_clr_i;
  logic                 rx_fifo_clr_i;
  uart_pkg::uart_byte_t wdata_i;
  logic                 wvalid_i;
  logic                 wready_o;
  uart_pkg::uart_byte_t rdata_o;
  logic                 rvalid_o;
  logic                 rready_i;
  logic [LvlW-1:0]      tx_lvl_o;
  logic [LvlW-1:0]      rx_lvl_o;
  logic                 tx_idle_o;
  logic                 rx_idle_o;
  logic                 rx_i;
  logic                 tx_o;
  logic                 rx_frame_err_o;
  logic                 rx_parity_err_o;
  logic                 rx_overflow_o;

  // line source select, high for loopback from tx_o
  logic                 loop_sel;
  logic                 gen_line;
  logic                 expect_wr;
  logic [31:0]          lcg_state = 32'hc18c_e0ad;
  uart_pkg::uart_byte_t exp_q[$];
  uart_pkg::uart_byte_t exp_head;
  int                   rd_cnt = 0;
  int                   frame_err_cnt = 0;
  int                   parity_err_cnt = 0;
  int                   overflow_cnt = 0;

  always #ClkHalf clk_i = ~clk_i;

  assign rx_i = loop_sel ? tx_o : gen_line;

  uart_top #(
    .FifoDepth (FifoDepth)
  ) i_uart_top (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .nco_i           (nco_i),
    .tx_en_i         (tx_en_i),
    .rx_en_i         (rx_en_i),
    .parity_en_i     (parity_en_i),
    .parity_odd_i    (parity_odd_i),
    .tx_fifo_clr_i   (tx_fifo_clr_i),
    .rx_fifo_clr_i   (rx_fifo_clr_i),
    .wdata_i         (wdata_i),
    .wvalid_i        (wvalid_i),
    .wready_o        (wready_o),
    .rdata_o         (rdata_o),
    .rvalid_o        (rvalid_o),
    .rready_i        (rready_i),
    .tx_lvl_o        (tx_lvl_o),
    .rx_lvl_o        (rx_lvl_o),
    .tx_idle_o       (tx_idle_o),
    .rx_idle_o       (rx_idle_o),
    .rx_i            (rx_i),
    .tx_o            (tx_o),
    .rx_frame_err_o  (rx_frame_err_o),
    .rx_parity_err_o (rx_parity_err_o),
    .rx_overflow_o   (rx_overflow_o)
  );

  ////////////////////////////////////////////////////////////
  // failure reporting
  ////////////////////////////////////////////////////////////

  task automatic stop_with_fail();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic fail_check(input string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    stop_with_fail();
  endtask

  task automatic fail_timeout(input string what);
    $display("timeout at %0t: %s never happened", $time, what);
    stop_with_fail();
  endtask

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // line levels of one frame, bit 0 goes out first
  function automatic logic [10:0] frame_bits(input uart_pkg::uart_byte_t b,
                                             input logic par_en, input logic par_odd);
    logic [10:0] f;
    f      = '1;
    f[0]   = 1'b0;
    f[8:1] = b;
    if (par_en) begin
      f[9] = (^b) ^ par_odd;
    end
    return f;
  endfunction

  function automatic int frame_len(input logic par_en);
    return par_en ? 11 : 10;
  endfunction

  task automatic next_byte(output uart_pkg::uart_byte_t b);
    lcg_state = lcg_next(lcg_state);
    b = lcg_state[31:24];
  endtask

  ////////////////////////////////////////////////////////////
  // compare process
  ////////////////////////////////////////////////////////////

  // expected bytes enter at the write port, leave at the read port
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (wvalid_i && wready_o && expect_wr) begin
        exp_q.push_back(wdata_i);
      end
      if (rvalid_o && rready_i) begin
        assert (exp_q.size() > 0)
        else fail_check($sformatf("read 0x%02h while no byte was expected", rdata_o));
        exp_head = exp_q.pop_front();
        assert (rdata_o == exp_head)
        else fail_check($sformatf("rdata_o is 0x%02h, expected 0x%02h", rdata_o, exp_head));
        rd_cnt++;
      end
      if (rx_frame_err_o) frame_err_cnt++;
      if (rx_parity_err_o) parity_err_cnt++;
      if (rx_overflow_o) overflow_cnt++;
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus and waits
  ////////////////////////////////////////////////////////////

  task automatic write_byte(input uart_pkg::uart_byte_t b);
    int n;
    n = 0;
    @(negedge clk_i);
    wdata_i  = b;
    wvalid_i = 1'b1;
    while (!wready_o) begin
      @(negedge clk_i);
      n++;
      if (n > WaitLimit) fail_timeout("write port ready");
    end
    // the rising edge in between takes the byte
    @(negedge clk_i);
    wvalid_i = 1'b0;
  endtask

  task automatic wait_reads(input int target);
    int n;
    n = 0;
    while (rd_cnt < target) begin
      @(negedge clk_i);
      n++;
      if (n > WaitLimit) fail_timeout($sformatf("read number %0d", target));
    end
  endtask

  task automatic wait_overflow(input int target);
    int n;
    n = 0;
    while (overflow_cnt < target) begin
      @(negedge clk_i);
      n++;
      if (n > WaitLimit) fail_timeout("receive overflow pulse");
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (!(tx_idle_o && rx_idle_o && tx_o)) begin
      @(negedge clk_i);
      n++;
      if (n > WaitLimit) fail_timeout("transmit and receive idle");
    end
  endtask

  // bit-banged frame on the generator line
  task automatic send_frame(input logic [10:0] f, input int len);
    for (int i = 0; i < len; i++) begin
      @(negedge clk_i);
      gen_line = f[i];
      repeat (BitCycles - 1) @(negedge clk_i);
    end
    @(negedge clk_i);
    gen_line = 1'b1;
  endtask

  // samples tx_o at mid-bit from the falling start edge on
  task automatic check_frame(input uart_pkg::uart_byte_t b);
    logic [10:0] exp_f;
    int          len;
    int          n;
    logic        prev;
    logic        found;
    exp_f = frame_bits(b, parity_en_i, parity_odd_i);
    len   = frame_len(parity_en_i);
    n     = 0;
    found = 1'b0;
    prev  = tx_o;
    while (!found) begin
      @(negedge clk_i);
      found = prev && !tx_o;
      prev  = tx_o;
      n++;
      if (n > WaitLimit) fail_timeout("start edge on tx_o");
    end
    repeat (BitCycles / 2 - 1) @(negedge clk_i);
    for (int i = 0; i < len; i++) begin
      if (i > 0) repeat (BitCycles) @(negedge clk_i);
      assert (tx_o == exp_f[i])
      else fail_check($sformatf("tx_o bit %0d of byte 0x%02h is %b, expected %b",
                                i, b, tx_o, exp_f[i]));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    uart_pkg::uart_byte_t b;
    logic [10:0]          frame;
    int                   rd_base;
    int                   fe_base;
    int                   pe_base;
    int                   ov_base;
    rst_ni        = 1'b0;
    nco_i         = NcoBaud;
    tx_en_i       = 1'b1;
    rx_en_i       = 1'b1;
    parity_en_i   = 1'b0;
    parity_odd_i  = 1'b0;
    tx_fifo_clr_i = 1'b0;
    rx_fifo_clr_i = 1'b0;
    wdata_i       = '0;
    wvalid_i      = 1'b0;
    rready_i      = 1'b1;
    loop_sel      = 1'b1;
    gen_line      = 1'b1;
    expect_wr     = 1'b1;
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    // 1: reset values
    assert (tx_o && wready_o && !rvalid_o)
    else fail_check("tx_o, wready_o or rvalid_o wrong after reset");
    assert (tx_lvl_o == '0 && rx_lvl_o == '0) else fail_check("levels not 0 after reset");
    assert (tx_idle_o && rx_idle_o) else fail_check("idle outputs low after reset");

    // 2: loopback without parity
    rd_base = rd_cnt;
    fe_base = frame_err_cnt;
    pe_base = parity_err_cnt;
    ov_base = overflow_cnt;
    repeat (20) begin
      next_byte(b);
      write_byte(b);
    end
    wait_reads(rd_base + 20);
    wait_idle();
    assert (exp_q.size() == 0) else fail_check("bytes left over after loopback");

    // 3: even then odd parity, first frame checked on the line
    for (int odd = 0; odd < 2; odd++) begin
      parity_en_i  = 1'b1;
      parity_odd_i = (odd == 1);
      rd_base = rd_cnt;
      next_byte(b);
      write_byte(b);
      check_frame(b);
      repeat (3) begin
        next_byte(b);
        write_byte(b);
      end
      wait_reads(rd_base + 4);
      wait_idle();
    end
    assert (frame_err_cnt == fe_base && parity_err_cnt == pe_base && overflow_cnt == ov_base)
    else fail_check("error pulse seen during clean loopback");

    // 4: bad frames from the generator, kept out of the receive FIFO
    @(negedge clk_i);
    parity_en_i  = 1'b0;
    parity_odd_i = 1'b0;
    loop_sel     = 1'b0;
    rready_i     = 1'b0;
    rd_base = rd_cnt;
    next_byte(b);
    frame    = frame_bits(b, 1'b0, 1'b0);
    frame[9] = 1'b0;
    send_frame(frame, 10);
    wait_idle();
    assert (frame_err_cnt == fe_base + 1 && parity_err_cnt == pe_base)
    else fail_check("low stop bit did not give exactly one frame error");
    assert (!rvalid_o && rx_lvl_o == '0) else fail_check("frame with error reached the FIFO");
    repeat (BitCycles) @(negedge clk_i);
    parity_en_i = 1'b1;
    next_byte(b);
    frame    = frame_bits(b, 1'b1, 1'b0);
    frame[9] = ~frame[9];
    send_frame(frame, 11);
    wait_idle();
    assert (parity_err_cnt == pe_base + 1 && frame_err_cnt == fe_base + 1)
    else fail_check("wrong parity bit did not give exactly one parity error");
    assert (!rvalid_o && rx_lvl_o == '0 && rd_cnt == rd_base)
    else fail_check("frame with parity error reached the FIFO");
    parity_en_i = 1'b0;
    loop_sel    = 1'b1;

    // 5: undrained receive FIFO overflows once
    rd_base = rd_cnt;
    repeat (FifoDepth) begin
      next_byte(b);
      write_byte(b);
    end
    expect_wr = 1'b0;
    next_byte(b);
    write_byte(b);
    expect_wr = 1'b1;
    wait_overflow(ov_base + 1);
    wait_idle();
    assert (overflow_cnt == ov_base + 1) else fail_check("overflow pulse count not 1");
    assert (rx_lvl_o == LvlW'(FifoDepth))
    else fail_check($sformatf("rx_lvl_o is %0d, expected %0d", rx_lvl_o, FifoDepth));
    rready_i = 1'b1;
    wait_reads(rd_base + FifoDepth);
    assert (rx_lvl_o == '0 && exp_q.size() == 0) else fail_check("receive FIFO not drained");

    // 6: transmit FIFO clear with the serializer disabled
    tx_en_i   = 1'b0;
    expect_wr = 1'b0;
    repeat (3) begin
      next_byte(b);
      write_byte(b);
    end
    assert (tx_lvl_o == LvlW'(3))
    else fail_check($sformatf("tx_lvl_o is %0d, expected 3", tx_lvl_o));
    tx_fifo_clr_i = 1'b1;
    @(negedge clk_i);
    tx_fifo_clr_i = 1'b0;
    assert (tx_lvl_o == '0 && tx_o) else fail_check("transmit FIFO not empty after clear");
    tx_en_i = 1'b1;
    repeat (2 * BitCycles) begin
      @(negedge clk_i);
      assert (tx_o && tx_lvl_o == '0) else fail_check("tx_o left idle after clear");
    end
    expect_wr = 1'b1;

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# compile the testbench and the RTL with Verilator, then run the simulation
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
  --top-module uart_tb \
  -f uart_lite.f \
  -o uart_sim

./obj_dir/uart_sim

// File: src/uart_baud_gen.sv
// tick rate is nco_i / 2**NcoWidth per clock, at most one tick per cycle; phase holds while disabled
`default_nettype none

module uart_baud_gen (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           enable_i,
  input  uart_pkg::nco_t nco_i,
  output logic           tick_x16_o
);

  // one extra bit on top holds the carry
  logic [uart_pkg::NcoWidth:0] nco_sum_q;

  ////////////////////////////////////////////////////////////
  // phase accumulator
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      nco_sum_q <= '0;
    end else if (enable_i) begin
      nco_sum_q <= {1'b0, nco_sum_q[uart_pkg::NcoWidth-1:0]} + {1'b0, nco_i};
    end else begin
      // keep the phase, drop a pending carry so no stale tick shows on restart
      nco_sum_q[uart_pkg::NcoWidth] <= 1'b0;
    end
  end

  // carry out is the 16x oversample tick
  assign tick_x16_o = nco_sum_q[uart_pkg::NcoWidth];

endmodule

`default_nettype wire

// File: src/uart_fifo.sv
// no pass-through: a pushed byte shows on the read side one cycle later; clr_i wins over a push
`default_nettype none

module uart_fifo #(
  parameter int Depth = 32
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clr_i,
  input  logic                   wvalid_i,
  output logic                   wready_o,
  input  uart_pkg::uart_byte_t   wdata_i,
  output logic                   rvalid_o,
  input  logic                   rready_i,
  output uart_pkg::uart_byte_t   rdata_o,
  output logic [$clog2(Depth):0] depth_o
);

  localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int LvlW = $clog2(Depth) + 1;

  uart_pkg::uart_byte_t mem_q [Depth];
  logic [PtrW-1:0]      wr_ptr_q;
  logic [PtrW-1:0]      rd_ptr_q;
  logic [LvlW-1:0]      count_q;
  logic                 push;
  logic                 pop;

  // pointer step with an explicit wrap, so any depth works
  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
    if (ptr == PtrW'(Depth - 1)) begin
      return '0;
    end
    return ptr + PtrW'(1);
  endfunction

  assign wready_o = (count_q != LvlW'(Depth));
  assign rvalid_o = (count_q != '0);
  assign push     = wvalid_i & wready_o;
  assign pop      = rvalid_o & rready_i;
  assign rdata_o  = mem_q[rd_ptr_q];
  assign depth_o  = count_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clr_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // simultaneous push and pop keeps the level
      if (push && !pop) begin
        count_q <= count_q + LvlW'(1);
      end else if (pop && !push) begin
        count_q <= count_q - LvlW'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

  // the level never runs past the depth, so no push lands on a full buffer
  level_bound_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q <= LvlW'(Depth));

  // an empty or full buffer has both pointers on the same slot, so no pop drains an empty one
  ptr_match_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (count_q == '0 || count_q == LvlW'(Depth)) |-> wr_ptr_q == rd_ptr_q);

endmodule

`default_nettype wire

// File: src/uart_pkg.sv
// widths assume 8-bit characters and 16x oversampling; the tx and rx counters are sized from them
`default_nettype none

package uart_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  // bits in one character
  parameter int DataWidth = 8;

  // width of the baud increment, the accumulator carries at 2**NcoWidth
  parameter int NcoWidth = 16;

  // baud ticks per serial bit
  parameter int OversampleRate = 16;

  typedef logic [DataWidth-1:0] uart_byte_t;
  typedef logic [NcoWidth-1:0] nco_t;
  typedef logic [$clog2(OversampleRate)-1:0] os_cnt_t;

  ////////////////////////////////////////////////////////////
  // FSM states
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    TxIdle,
    TxStart,
    TxData,
    TxParity,
    TxStop
  } tx_state_e;

  typedef enum logic [2:0] {
    RxIdle,
    RxStart,
    RxData,
    RxParity,
    RxStop
  } rx_state_e;

endpackage

`default_nettype wire

// File: src/uart_rx.sv
// a frame starts on a falling edge seen while idle; parity settings must not change mid-frame
`default_nettype none

module uart_rx (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 rx_en_i,
  input  logic                 tick_x16_i,
  input  logic                 parity_en_i,
  input  logic                 parity_odd_i,
  input  logic                 rx_i,
  output logic                 valid_o,
  output uart_pkg::uart_byte_t data_o,
  output logic                 frame_err_o,
  output logic                 parity_err_o,
  output logic                 idle_o
);

  localparam int BitCntW = $clog2(uart_pkg::DataWidth);
  localparam uart_pkg::os_cnt_t TickLast = uart_pkg::os_cnt_t'(uart_pkg::OversampleRate - 1);
  localparam uart_pkg::os_cnt_t TickHalf = uart_pkg::os_cnt_t'(uart_pkg::OversampleRate / 2 - 1);

  logic [1:0]           sync_q;
  logic                 rx_in;
  logic                 rx_prev_q;
  logic                 start_edge;
  uart_pkg::rx_state_e  state_q;
  uart_pkg::os_cnt_t    tick_cnt_q;
  logic [BitCntW-1:0]   bit_cnt_q;
  uart_pkg::uart_byte_t shift_q;
  logic                 parity_q;
  logic                 par_err_q;
  logic                 valid_q;
  logic                 frame_err_q;
  logic                 parity_err_q;
  logic                 sample_half;
  logic                 sample_full;

  ////////////////////////////////////////////////////////////
  // input synchronizer
  ////////////////////////////////////////////////////////////

  // resets to the idle line level so reset release is not a start edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sync_q    <= 2'b11;
      rx_prev_q <= 1'b1;
    end else begin
      sync_q    <= {sync_q[0], rx_i};
      rx_prev_q <= rx_in;
    end
  end

  assign rx_in      = sync_q[1];
  // a line held low after a frame error does not restart a frame
  assign start_edge = rx_prev_q & ~rx_in;

  assign sample_half = tick_x16_i & (tick_cnt_q == TickHalf);
  assign sample_full = tick_x16_i & (tick_cnt_q == TickLast);

  ////////////////////////////////////////////////////////////
  // frame FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= uart_pkg::RxIdle;
      tick_cnt_q   <= '0;
      bit_cnt_q    <= '0;
      parity_q     <= 1'b0;
      par_err_q    <= 1'b0;
      valid_q      <= 1'b0;
      frame_err_q  <= 1'b0;
      parity_err_q <= 1'b0;
    end else begin
      valid_q      <= 1'b0;
      frame_err_q  <= 1'b0;
      parity_err_q <= 1'b0;
      if (!rx_en_i) begin
        state_q    <= uart_pkg::RxIdle;
        tick_cnt_q <= '0;
      end else begin
        if (state_q != uart_pkg::RxIdle && tick_x16_i) begin
          tick_cnt_q <= tick_cnt_q + 1'b1;
        end
        unique case (state_q)
          uart_pkg::RxIdle: begin
            if (start_edge) begin
              state_q    <= uart_pkg::RxStart;
              tick_cnt_q <= '0;
            end
          end
          uart_pkg::RxStart: begin
            // mid start bit, a high line here was a glitch
            if (sample_half) begin
              tick_cnt_q <= '0;
              if (rx_in) begin
                state_q <= uart_pkg::RxIdle;
              end else begin
                state_q   <= uart_pkg::RxData;
                bit_cnt_q <= '0;
                parity_q  <= parity_odd_i;
                par_err_q <= 1'b0;
              end
            end
          end
          uart_pkg::RxData: begin
            if (sample_full) begin
              parity_q  <= parity_q ^ rx_in;
              bit_cnt_q <= bit_cnt_q + 1'b1;
              if (bit_cnt_q == BitCntW'(uart_pkg::DataWidth - 1)) begin
                state_q <= parity_en_i ? uart_pkg::RxParity : uart_pkg::RxStop;
              end
            end
          end
          uart_pkg::RxParity: begin
            if (sample_full) begin
              par_err_q <= (rx_in != parity_q);
              state_q   <= uart_pkg::RxStop;
            end
          end
          uart_pkg::RxStop: begin
            if (sample_full) begin
              state_q      <= uart_pkg::RxIdle;
              valid_q      <= 1'b1;
              frame_err_q  <= ~rx_in;
              parity_err_q <= par_err_q & parity_en_i;
            end
          end
          default: begin
            state_q <= uart_pkg::RxIdle;
          end
        endcase
      end
    end
  end

  // data bits arrive LSB first
  always_ff @(posedge clk_i) begin
    if (rx_en_i && state_q == uart_pkg::RxData && sample_full) begin
      shift_q <= {rx_in, shift_q[uart_pkg::DataWidth-1:1]};
    end
  end

  assign valid_o      = valid_q;
  assign data_o       = shift_q;
  assign frame_err_o  = frame_err_q;
  assign parity_err_o = parity_err_q;
  assign idle_o       = (state_q == uart_pkg::RxIdle);

  // an error flag only comes with the valid pulse, and that pulse lasts one cycle
  err_with_valid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (frame_err_o || parity_err_o) |-> valid_o ##1 !valid_o);

endmodule

`default_nettype wire

// File: src/uart_top.sv
// the serial line has no flow control: bytes that reach a full receive FIFO are dropped
`default_nettype none

module uart_top #(
  parameter int FifoDepth = 32
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  uart_pkg::nco_t             nco_i,
  input  logic                       tx_en_i,
  input  logic                       rx_en_i,
  input  logic                       parity_en_i,
  input  logic                       parity_odd_i,
  input  logic                       tx_fifo_clr_i,
  input  logic                       rx_fifo_clr_i,
  input  uart_pkg::uart_byte_t       wdata_i,
  input  logic                       wvalid_i,
  output logic                       wready_o,
  output uart_pkg::uart_byte_t       rdata_o,
  output logic                       rvalid_o,
  input  logic                       rready_i,
  output logic [$clog2(FifoDepth):0] tx_lvl_o,
  output logic [$clog2(FifoDepth):0] rx_lvl_o,
  output logic                       tx_idle_o,
  output logic                       rx_idle_o,
  input  logic                       rx_i,
  output logic                       tx_o,
  output logic                       rx_frame_err_o,
  output logic                       rx_parity_err_o,
  output logic                       rx_overflow_o
);

  logic                 tick_x16;
  logic                 tx_fifo_rvalid;
  uart_pkg::uart_byte_t tx_fifo_data;
  logic                 tx_pop;
  logic                 tx_ser_idle;
  logic                 rx_valid;
  uart_pkg::uart_byte_t rx_data;
  logic                 rx_push;
  logic                 rx_fifo_wready;

  // baud ticks run while either direction is enabled
  uart_baud_gen u_baud_gen (
    .clk_i,
    .rst_ni,
    .enable_i   (tx_en_i | rx_en_i),
    .nco_i,
    .tick_x16_o (tick_x16)
  );

  ////////////////////////////////////////////////////////////
  // transmit path
  ////////////////////////////////////////////////////////////

  uart_fifo #(
    .Depth (FifoDepth)
  ) u_tx_fifo (
    .clk_i,
    .rst_ni,
    .clr_i    (tx_fifo_clr_i),
    .wvalid_i,
    .wready_o,
    .wdata_i,
    .rvalid_o (tx_fifo_rvalid),
    .rready_i (tx_pop),
    .rdata_o  (tx_fifo_data),
    .depth_o  (tx_lvl_o)
  );

  uart_tx u_tx (
    .clk_i,
    .rst_ni,
    .tx_en_i,
    .tick_x16_i   (tick_x16),
    .parity_en_i,
    .parity_odd_i,
    .fifo_valid_i (tx_fifo_rvalid),
    .fifo_data_i  (tx_fifo_data),
    .fifo_pop_o   (tx_pop),
    .idle_o       (tx_ser_idle),
    .tx_o
  );

  // idle only once nothing is left to send
  assign tx_idle_o = tx_ser_idle & ~tx_fifo_rvalid;

  ////////////////////////////////////////////////////////////
  // receive path
  ////////////////////////////////////////////////////////////

  uart_rx u_rx (
    .clk_i,
    .rst_ni,
    .rx_en_i,
    .tick_x16_i   (tick_x16),
    .parity_en_i,
    .parity_odd_i,
    .rx_i,
    .valid_o      (rx_valid),
    .data_o       (rx_data),
    .frame_err_o  (rx_frame_err_o),
    .parity_err_o (rx_parity_err_o),
    .idle_o       (rx_idle_o)
  );

  // bad frames never reach the FIFO
  assign rx_push       = rx_valid & ~rx_frame_err_o & ~rx_parity_err_o;
  assign rx_overflow_o = rx_push & ~rx_fifo_wready;

  uart_fifo #(
    .Depth (FifoDepth)
  ) u_rx_fifo (
    .clk_i,
    .rst_ni,
    .clr_i    (rx_fifo_clr_i),
    .wvalid_i (rx_push),
    .wready_o (rx_fifo_wready),
    .wdata_i  (rx_data),
    .rvalid_o,
    .rready_i,
    .rdata_o,
    .depth_o  (rx_lvl_o)
  );

  // a lost byte means the receive FIFO really is at its full level
  overflow_full_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_overflow_o |-> rx_lvl_o == ($clog2(FifoDepth) + 1)'(FifoDepth));

endmodule

`default_nettype wire

// File: src/uart_tx.sv
// 1 start bit, 8 data bits LSB first, optional parity, 1 stop bit; parity settings must not change mid-frame
`default_nettype none

module uart_tx (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 tx_en_i,
  input  logic                 tick_x16_i,
  input  logic                 parity_en_i,
  input  logic                 parity_odd_i,
  input  logic                 fifo_valid_i,
  input  uart_pkg::uart_byte_t fifo_data_i,
  output logic                 fifo_pop_o,
  output logic                 idle_o,
  output logic                 tx_o
);

  localparam int BitCntW = $clog2(uart_pkg::DataWidth);
  localparam uart_pkg::os_cnt_t TickLast = uart_pkg::os_cnt_t'(uart_pkg::OversampleRate - 1);

  uart_pkg::tx_state_e  state_q;
  uart_pkg::os_cnt_t    tick_cnt_q;
  logic [BitCntW-1:0]   bit_cnt_q;
  uart_pkg::uart_byte_t shift_q;
  logic                 parity_q;
  logic                 tx_q;
  logic                 bit_first;
  logic                 bit_last;

  assign idle_o     = (state_q == uart_pkg::TxIdle);
  assign fifo_pop_o = tx_en_i & fifo_valid_i & idle_o;
  assign tx_o       = tx_q;

  // first and last tick of the bit on the line
  assign bit_first = tick_x16_i & (tick_cnt_q == '0);
  assign bit_last  = tick_x16_i & (tick_cnt_q == TickLast);

  ////////////////////////////////////////////////////////////
  // frame FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= uart_pkg::TxIdle;
      tick_cnt_q <= '0;
      bit_cnt_q  <= '0;
      parity_q   <= 1'b0;
      tx_q       <= 1'b1;
    end else if (!tx_en_i) begin
      // disabling aborts the frame and releases the line
      state_q    <= uart_pkg::TxIdle;
      tick_cnt_q <= '0;
      tx_q       <= 1'b1;
    end else begin
      if (!idle_o && tick_x16_i) begin
        tick_cnt_q <= tick_cnt_q + 1'b1;
      end
      unique case (state_q)
        uart_pkg::TxIdle: begin
          tx_q <= 1'b1;
          if (fifo_pop_o) begin
            state_q    <= uart_pkg::TxStart;
            tick_cnt_q <= '0;
            bit_cnt_q  <= '0;
            // odd parity starts the running XOR at one
            parity_q   <= parity_odd_i;
          end
        end
        uart_pkg::TxStart: begin
          if (bit_first) begin
            tx_q <= 1'b0;
          end
          if (bit_last) begin
            state_q <= uart_pkg::TxData;
          end
        end
        uart_pkg::TxData: begin
          if (bit_first) begin
            tx_q <= shift_q[0];
          end
          if (bit_last) begin
            parity_q  <= parity_q ^ shift_q[0];
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == BitCntW'(uart_pkg::DataWidth - 1)) begin
              state_q <= parity_en_i ? uart_pkg::TxParity : uart_pkg::TxStop;
            end
          end
        end
        uart_pkg::TxParity: begin
          if (bit_first) begin
            tx_q <= parity_q;
          end
          if (bit_last) begin
            state_q <= uart_pkg::TxStop;
          end
        end
        uart_pkg::TxStop: begin
          if (bit_first) begin
            tx_q <= 1'b1;
          end
          if (bit_last) begin
            state_q <= uart_pkg::TxIdle;
          end
        end
        default: begin
          state_q <= uart_pkg::TxIdle;
        end
      endcase
    end
  end

  // byte latched on the pop, shifted out LSB first
  always_ff @(posedge clk_i) begin
    if (fifo_pop_o) begin
      shift_q <= fifo_data_i;
    end else if (state_q == uart_pkg::TxData && bit_last) begin
      shift_q <= shift_q >> 1;
    end
  end

  // a pop is only taken from idle and leaves the serializer busy on the next cycle
  pop_from_idle_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fifo_pop_o |-> (state_q == uart_pkg::TxIdle) ##1 !idle_o);

endmodule

`default_nettype wire

// File: uart_lite.f
src/uart_pkg.sv
src/uart_fifo.sv
src/uart_baud_gen.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_top.sv
dv/uart_tb.sv
